// File: source/stq_settings.svh
`ifndef STQ_SETTINGS_SVH
`define STQ_SETTINGS_SVH

// number of store queue entries, a power of two so ring indices wrap on their own.
`define STQ_DEPTH 8
`define STQ_IDX_W 3

// load check ports compared in parallel against every entry.
`define STQ_CHK_PORTS 2

`define STQ_ADDR_W 36   // even/odd line address.
`define STQ_BYTES_W 4   // bytes within one bank word.
`define STQ_BANK_W 8    // sub-banks of a line.

`endif

// File: source/stq_addr_pkg.sv
`include "stq_settings.svh"

package stq_addr_pkg;

  typedef logic [`STQ_ADDR_W-1:0] addr_t;
  typedef logic [`STQ_BYTES_W-1:0] bytes_t;
  typedef logic [`STQ_BANK_W-1:0] bank_t;

  // everything needed to decide whether two accesses touch the same bytes.
  typedef struct packed {
    addr_t  addr;
    logic   odd;     // selects the odd half of the even/odd line pair.
    bytes_t bytes;
    bank_t  bank;
  } footprint_t;

endpackage

// File: source/stq_ctrl_pkg.sv
`include "stq_settings.svh"

package stq_ctrl_pkg;

  typedef logic [`STQ_IDX_W-1:0] idx_t;

  // one store write slot.
  typedef struct packed {
    logic                     en;
    stq_addr_pkg::footprint_t fp;
  } wrt_req_t;

  // one load looking for older stores to the same bytes.
  typedef struct packed {
    logic                     en;
    stq_addr_pkg::footprint_t fp;
  } chk_req_t;

  // match means the data can be forwarded from entry idx.
  // partial means the load overlaps a store it cannot use and has to wait.
  typedef struct packed {
    logic match;
    logic partial;
    idx_t idx;
  } chk_res_t;

  typedef struct packed {
    logic free;
    logic upd;    // store data has arrived.
    logic passe;  // store has been written to the cache.
  } entry_state_t;

endpackage

// File: source/stq_entry.sv
`timescale 1ns/1ps
`include "stq_settings.svh"

module stq_entry (
  input  logic                        clk,
  input  logic                        rst,
  input  stq_ctrl_pkg::wrt_req_t      wr0,
  input  stq_ctrl_pkg::wrt_req_t      wr1,
  input  logic                        wr0_sel,
  input  logic                        wr1_sel,
  input  logic                        upd_hit,
  input  logic                        drain_hit,
  input  logic                        free_en,
  input  stq_ctrl_pkg::chk_req_t      chk [`STQ_CHK_PORTS],
  output logic [`STQ_CHK_PORTS-1:0]   match,
  output logic [`STQ_CHK_PORTS-1:0]   partial,
  output stq_ctrl_pkg::entry_state_t  state
);

  stq_addr_pkg::footprint_t fp;
  logic take0;
  logic take1;
  logic [`STQ_CHK_PORTS-1:0] hit;
  logic [`STQ_CHK_PORTS-1:0] covered;

  assign take0 = wr0_sel && wr0.en;
  assign take1 = wr1_sel && wr1.en;

  always_ff @(posedge clk) begin
    if (take0) fp <= wr0.fp;
    if (take1) fp <= wr1.fp;  // slot 1 is the younger store.
  end

  // later statements win, so a free in the same cycle as a drain leaves passe clear.
  always_ff @(posedge clk) begin
    if (rst) begin
      state.free <= 1'b1;
      state.upd <= 1'b1;
      state.passe <= 1'b0;
    end else begin
      if (take0 || take1) begin
        state.free <= 1'b0;
        state.upd <= 1'b0;
        state.passe <= 1'b0;
      end
      if (upd_hit) state.upd <= 1'b1;
      if (drain_hit) state.passe <= 1'b1;
      if (free_en) begin
        state.free <= 1'b1;
        state.passe <= 1'b0;
      end
    end
  end

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_port
    // same line, same half and at least one shared sub-bank.
    assign hit[p] = chk[p].en && !state.free && !state.passe
                    && chk[p].fp.addr == fp.addr
                    && chk[p].fp.odd == fp.odd
                    && (chk[p].fp.bank & fp.bank) != '0;

    assign covered[p] = (chk[p].fp.bytes & ~fp.bytes) == '0;  // load bytes inside the store.

    assign match[p] = hit[p] && covered[p] && state.upd;
    assign partial[p] = hit[p] && (!covered[p] || !state.upd);
  end

  a_wr_free: assert property (@(posedge clk) disable iff (rst)
    (take0 || take1) |-> state.free)
    else $error("store written into an entry that is still occupied.");

endmodule

// File: source/stq_alloc.sv
`timescale 1ns/1ps
`include "stq_settings.svh"

module stq_alloc (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [1:0]                  wrt_en,
  input  stq_ctrl_pkg::entry_state_t  state [`STQ_DEPTH],
  output logic [`STQ_DEPTH-1:0]       wr0_sel,
  output logic [`STQ_DEPTH-1:0]       wr1_sel,
  output logic [`STQ_DEPTH-1:0]       free_sel,
  output stq_ctrl_pkg::idx_t          head,
  output logic [1:0]                  space,
  output logic [`STQ_IDX_W:0]         count
);

  typedef logic [`STQ_IDX_W:0] cnt_t;

  stq_ctrl_pkg::idx_t tail;
  stq_ctrl_pkg::idx_t tail_nxt;
  logic acc0;
  logic acc1;
  logic do_free;

  // space is the number of free entries, saturated at two.
  always_comb begin
    if (count <= cnt_t'(`STQ_DEPTH - 2)) space = 2'd2;
    else if (count == cnt_t'(`STQ_DEPTH - 1)) space = 2'd1;
    else space = 2'd0;
  end

  assign acc0 = wrt_en[0] && space != 2'd0;
  assign acc1 = wrt_en[1] && wrt_en[0] && space == 2'd2;

  // the head leaves once its store has reached the cache.
  assign do_free = count != '0 && !state[head].free && state[head].passe;

  assign tail_nxt = tail + 1'b1;

  always_comb begin
    wr0_sel = '0;
    wr1_sel = '0;
    free_sel = '0;
    wr0_sel[tail] = acc0;
    wr1_sel[tail_nxt] = acc1;
    free_sel[head] = do_free;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      tail <= tail + stq_ctrl_pkg::idx_t'(acc0) + stq_ctrl_pkg::idx_t'(acc1);
      head <= head + stq_ctrl_pkg::idx_t'(do_free);
      count <= count + cnt_t'(acc0) + cnt_t'(acc1) - cnt_t'(do_free);
    end
  end

  // writes past space are dropped by design, the checks below only report them.
  a_room0: assert property (@(posedge clk) disable iff (rst)
    wrt_en[0] |-> space != 2'd0)
    else $warning("store write on slot 0 with a full queue is dropped.");

  a_room1: assert property (@(posedge clk) disable iff (rst)
    wrt_en[1] |-> space == 2'd2)
    else $warning("store write on slot 1 without room for two is dropped.");

  a_pair: assert property (@(posedge clk) disable iff (rst)
    wrt_en[1] |-> wrt_en[0])
    else $error("slot 1 written without slot 0.");

  a_count: assert property (@(posedge clk) disable iff (rst)
    count <= cnt_t'(`STQ_DEPTH))
    else $error("occupancy %0d is above the queue depth.", count);

endmodule

// File: source/stq_check_merge.sv
`timescale 1ns/1ps
`include "stq_settings.svh"

module stq_check_merge (
  input  logic                    chk_en,
  input  stq_ctrl_pkg::idx_t      head,
  input  logic [`STQ_DEPTH-1:0]   match_vec,
  input  logic [`STQ_DEPTH-1:0]   partial_vec,
  output stq_ctrl_pkg::chk_res_t  res
);

  stq_ctrl_pkg::idx_t age;
  stq_ctrl_pkg::idx_t best_age;
  stq_ctrl_pkg::idx_t best_idx;
  logic found;

  // age is the ring distance from the head, the largest one is the youngest store.
  always_comb begin
    found = 1'b0;
    best_age = '0;
    best_idx = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      age = stq_ctrl_pkg::idx_t'(i) - head;
      if (match_vec[i] && (!found || age > best_age)) begin
        found = 1'b1;
        best_age = age;
        best_idx = stq_ctrl_pkg::idx_t'(i);
      end
    end
  end

  assign res.partial = |partial_vec;  // any blocking overlap stalls the load.
  assign res.match = found && !res.partial;
  assign res.idx = res.match ? best_idx : '0;

  // the entries gate their vectors with the port enable, so an idle port stays quiet.
  a_idle: assert final (chk_en || res == '0)
    else $error("check result active on a disabled port.");

endmodule

// File: source/stq_top.sv
`timescale 1ns/1ps
`include "stq_settings.svh"

module stq_top (
  input  logic                    clk,
  input  logic                    rst,
  input  stq_ctrl_pkg::wrt_req_t  wrt [2],
  input  logic [1:0]              upd_en,
  input  stq_ctrl_pkg::idx_t      upd_idx [2],
  input  logic                    drain_en,
  input  stq_ctrl_pkg::idx_t      drain_idx,
  input  stq_ctrl_pkg::chk_req_t  chk [`STQ_CHK_PORTS],
  output stq_ctrl_pkg::chk_res_t  res [`STQ_CHK_PORTS],
  output logic [1:0]              space,
  output logic [`STQ_IDX_W:0]     count
);

  logic [`STQ_DEPTH-1:0] wr0_sel;
  logic [`STQ_DEPTH-1:0] wr1_sel;
  logic [`STQ_DEPTH-1:0] free_sel;
  logic [`STQ_DEPTH-1:0] upd_hit;
  logic [`STQ_DEPTH-1:0] drain_hit;
  stq_ctrl_pkg::idx_t head;
  stq_ctrl_pkg::entry_state_t ent_state [`STQ_DEPTH];
  logic [`STQ_CHK_PORTS-1:0] ent_match [`STQ_DEPTH];
  logic [`STQ_CHK_PORTS-1:0] ent_partial [`STQ_DEPTH];
  logic [`STQ_DEPTH-1:0] port_match [`STQ_CHK_PORTS];
  logic [`STQ_DEPTH-1:0] port_partial [`STQ_CHK_PORTS];

  stq_alloc u_alloc (
    .clk      (clk),
    .rst      (rst),
    .wrt_en   ({wrt[1].en, wrt[0].en}),
    .state    (ent_state),
    .wr0_sel  (wr0_sel),
    .wr1_sel  (wr1_sel),
    .free_sel (free_sel),
    .head     (head),
    .space    (space),
    .count    (count)
  );

  // both update strobes may name the same entry.
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      upd_hit[i] = (upd_en[0] && upd_idx[0] == stq_ctrl_pkg::idx_t'(i))
                   || (upd_en[1] && upd_idx[1] == stq_ctrl_pkg::idx_t'(i));
      drain_hit[i] = drain_en && drain_idx == stq_ctrl_pkg::idx_t'(i);
    end
  end

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_entry
    stq_entry u_entry (
      .clk       (clk),
      .rst       (rst),
      .wr0       (wrt[0]),
      .wr1       (wrt[1]),
      .wr0_sel   (wr0_sel[i]),
      .wr1_sel   (wr1_sel[i]),
      .upd_hit   (upd_hit[i]),
      .drain_hit (drain_hit[i]),
      .free_en   (free_sel[i]),
      .chk       (chk),
      .match     (ent_match[i]),
      .partial   (ent_partial[i]),
      .state     (ent_state[i])
    );
  end

  // turn per-entry port bits into per-port entry vectors.
  always_comb begin
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        port_match[p][i] = ent_match[i][p];
        port_partial[p][i] = ent_partial[i][p];
      end
    end
  end

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_merge
    stq_check_merge u_merge (
      .chk_en      (chk[p].en),
      .head        (head),
      .match_vec   (port_match[p]),
      .partial_vec (port_partial[p]),
      .res         (res[p])
    );
  end

endmodule

// File: test/stq_tb.sv
`timescale 1ns/1ps
`include "stq_settings.svh"

module stq_tb;

  localparam int DIRECTED_CYCLES = 150;
  localparam int RAND_CYCLES = 400;
  localparam int DRAIN_CYCLES = 40;
  localparam int RUN_CYCLES = 4 + DIRECTED_CYCLES + RAND_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS = RUN_CYCLES * 20 + 2000;

  logic clk;
  logic rst;
  stq_ctrl_pkg::wrt_req_t wrt [2];
  logic [1:0] upd_en;
  stq_ctrl_pkg::idx_t upd_idx [2];
  logic drain_en;
  stq_ctrl_pkg::idx_t drain_idx;
  stq_ctrl_pkg::chk_req_t chk [`STQ_CHK_PORTS];
  stq_ctrl_pkg::chk_res_t res [`STQ_CHK_PORTS];
  logic [1:0] space;
  logic [`STQ_IDX_W:0] count;

  integer seed;
  int errors;
  string test_name;

  // reference copy of every entry.
  stq_addr_pkg::footprint_t m_fp [`STQ_DEPTH];
  logic m_free [`STQ_DEPTH];
  logic m_upd [`STQ_DEPTH];
  logic m_passe [`STQ_DEPTH];
  stq_ctrl_pkg::idx_t m_head;
  stq_ctrl_pkg::idx_t m_tail;
  int m_count;

  stq_ctrl_pkg::chk_res_t exp_res [`STQ_CHK_PORTS];
  logic [1:0] exp_space;

  stq_addr_pkg::addr_t addr_pool [4];
  stq_addr_pkg::bank_t bank_pool [4];

  stq_top uut (
    .clk       (clk),
    .rst       (rst),
    .wrt       (wrt),
    .upd_en    (upd_en),
    .upd_idx   (upd_idx),
    .drain_en  (drain_en),
    .drain_idx (drain_idx),
    .chk       (chk),
    .res       (res),
    .space     (space),
    .count     (count)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    errors++;
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string what, input int unsigned exp_v,
                                 input int unsigned act_v);
    $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    abort_run("the DUT returned a wrong value.");
  endtask

  // the write order is slot 0, slot 1, updates, drain, then the head leaving.
  always @(posedge clk) begin : model
    int room;
    logic a0;
    logic a1;
    logic do_free;
    logic n_free;
    logic n_upd;
    logic n_passe;
    stq_ctrl_pkg::idx_t t1;
    stq_ctrl_pkg::idx_t e;
    if (rst) begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        m_free[i] <= 1'b1;
        m_upd[i] <= 1'b1;
        m_passe[i] <= 1'b0;
      end
      m_head <= '0;
      m_tail <= '0;
      m_count <= 0;
    end else begin
      room = `STQ_DEPTH - m_count;
      a0 = wrt[0].en && room >= 1;
      a1 = wrt[1].en && wrt[0].en && room >= 2;
      do_free = m_count > 0 && !m_free[m_head] && m_passe[m_head];
      t1 = m_tail + 1'b1;
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        e = stq_ctrl_pkg::idx_t'(i);
        n_free = m_free[i];
        n_upd = m_upd[i];
        n_passe = m_passe[i];
        if ((a0 && e == m_tail) || (a1 && e == t1)) begin
          n_free = 1'b0;
          n_upd = 1'b0;
          n_passe = 1'b0;
          m_fp[i] <= (a1 && e == t1) ? wrt[1].fp : wrt[0].fp;
        end
        if ((upd_en[0] && upd_idx[0] == e) || (upd_en[1] && upd_idx[1] == e)) n_upd = 1'b1;
        if (drain_en && drain_idx == e) n_passe = 1'b1;
        if (do_free && e == m_head) begin
          n_free = 1'b1;
          n_passe = 1'b0;
        end
        m_free[i] <= n_free;
        m_upd[i] <= n_upd;
        m_passe[i] <= n_passe;
      end
      m_tail <= m_tail + stq_ctrl_pkg::idx_t'(a0) + stq_ctrl_pkg::idx_t'(a1);
      m_head <= m_head + stq_ctrl_pkg::idx_t'(do_free);
      m_count <= m_count + a0 + a1 - do_free;
    end
  end

  // walk from the head so the last match seen is the youngest store.
  always_comb begin
    int room;
    logic hit;
    logic covered;
    logic any_partial;
    logic any_match;
    stq_ctrl_pkg::idx_t e;
    stq_ctrl_pkg::idx_t young;
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      any_partial = 1'b0;
      any_match = 1'b0;
      young = '0;
      for (int k = 0; k < `STQ_DEPTH; k++) begin
        e = m_head + stq_ctrl_pkg::idx_t'(k);
        hit = chk[p].en && !m_free[e] && !m_passe[e]
              && chk[p].fp.addr == m_fp[e].addr && chk[p].fp.odd == m_fp[e].odd
              && (chk[p].fp.bank & m_fp[e].bank) != '0;
        covered = (chk[p].fp.bytes & ~m_fp[e].bytes) == '0;
        if (hit && (!covered || !m_upd[e])) any_partial = 1'b1;
        if (hit && covered && m_upd[e]) begin
          any_match = 1'b1;
          young = e;
        end
      end
      exp_res[p].partial = any_partial;
      exp_res[p].match = any_match && !any_partial;
      exp_res[p].idx = (any_match && !any_partial) ? young : '0;
    end
    room = `STQ_DEPTH - m_count;
    exp_space = (room >= 2) ? 2'd2 : room[1:0];
  end

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_port
    a_match: assert property (@(posedge clk) disable iff (rst) res[p].match == exp_res[p].match)
      else report_mismatch($sformatf("match port %0d", p), $sampled(exp_res[p].match),
                           $sampled(res[p].match));
    a_partial: assert property (@(posedge clk) disable iff (rst)
      res[p].partial == exp_res[p].partial)
      else report_mismatch($sformatf("partial port %0d", p), $sampled(exp_res[p].partial),
                           $sampled(res[p].partial));
    a_idx: assert property (@(posedge clk) disable iff (rst) res[p].idx == exp_res[p].idx)
      else report_mismatch($sformatf("idx port %0d", p), $sampled(exp_res[p].idx),
                           $sampled(res[p].idx));
  end

  a_space: assert property (@(posedge clk) disable iff (rst) space == exp_space)
    else report_mismatch("space", $sampled(exp_space), $sampled(space));

  a_count: assert property (@(posedge clk) disable iff (rst) count == m_count)
    else report_mismatch("count", $sampled(m_count), $sampled(count));

  function automatic stq_addr_pkg::footprint_t make_fp(input stq_addr_pkg::addr_t addr,
      input logic odd, input stq_addr_pkg::bytes_t bytes, input stq_addr_pkg::bank_t bank);
    stq_addr_pkg::footprint_t fp;
    fp.addr = addr;
    fp.odd = odd;
    fp.bytes = bytes;
    fp.bank = bank;
    return fp;
  endfunction

  task automatic draw_fp(output stq_addr_pkg::footprint_t fp);
    logic [31:0] r;
    r = $random(seed);
    fp = make_fp(addr_pool[r[1:0]], r[2], r[6:3], bank_pool[r[8:7]]);
  endtask

  task automatic clear_strobes();
    wrt[0].en <= 1'b0;
    wrt[1].en <= 1'b0;
    upd_en <= 2'b00;
    drain_en <= 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    clear_strobes();
  endtask

  task automatic write_stores(input stq_addr_pkg::footprint_t fp0,
                              input stq_addr_pkg::footprint_t fp1, input logic two);
    @(posedge clk);
    clear_strobes();
    wrt[0].en <= 1'b1;
    wrt[0].fp <= fp0;
    wrt[1].en <= two;
    wrt[1].fp <= fp1;
  endtask

  task automatic update_entries(input stq_ctrl_pkg::idx_t i0, input stq_ctrl_pkg::idx_t i1);
    @(posedge clk);
    clear_strobes();
    upd_en <= 2'b11;
    upd_idx[0] <= i0;
    upd_idx[1] <= i1;
  endtask

  task automatic drain_entry(input stq_ctrl_pkg::idx_t idx);
    @(posedge clk);
    clear_strobes();
    drain_en <= 1'b1;
    drain_idx <= idx;
  endtask

  task automatic set_check(input int p, input logic en, input stq_addr_pkg::footprint_t fp);
    chk[p].en <= en;
    chk[p].fp <= fp;
  endtask

  function automatic stq_addr_pkg::footprint_t store_fp(input int n);
    return make_fp(36'h100 + n, 1'b0, 4'h3, 8'h01);
  endfunction

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
    abort_run("the run hung.");
  end

  initial begin : stimulus
    stq_addr_pkg::footprint_t f0;
    stq_addr_pkg::footprint_t f1;
    logic [31:0] r;
    seed = 32'hde72bc6e;
    errors = 0;
    addr_pool = '{36'h300, 36'h301, 36'h8_0000_0300, 36'h302};
    bank_pool = '{8'h01, 8'h03, 8'h0c, 8'hf0};
    rst = 1'b1;
    wrt[0] = '0;
    wrt[1] = '0;
    upd_en = 2'b00;
    upd_idx[0] = '0;
    upd_idx[1] = '0;
    drain_en = 1'b0;
    drain_idx = '0;
    for (int p = 0; p < `STQ_CHK_PORTS; p++) chk[p] = '0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    set_check(0, 1'b1, make_fp(36'h102, 1'b0, 4'h1, 8'h03));
    set_check(1, 1'b1, make_fp(36'h102, 1'b0, 4'h6, 8'h01));
    repeat (3) idle_cycle();

    test_name = "capacity";
    for (int i = 0; i < 6; i += 2) write_stores(store_fp(i), store_fp(i + 1), 1'b1);
    write_stores(store_fp(6), store_fp(6), 1'b0);
    write_stores(store_fp(7), store_fp(9), 1'b1);    // only slot 0 fits.
    write_stores(store_fp(10), store_fp(11), 1'b1);  // queue is full, both dropped.
    idle_cycle();

    test_name = "update";
    update_entries(2, 2);
    repeat (2) idle_cycle();

    test_name = "mismatch";
    set_check(0, 1'b1, make_fp(36'h1ff, 1'b0, 4'h1, 8'h01));
    set_check(1, 1'b1, make_fp(36'h102, 1'b1, 4'h1, 8'h01));
    repeat (2) idle_cycle();
    set_check(0, 1'b1, make_fp(36'h102, 1'b0, 4'h1, 8'h02));
    repeat (2) idle_cycle();

    test_name = "drain";
    set_check(0, 1'b1, make_fp(36'h102, 1'b0, 4'h3, 8'h01));
    for (int i = 0; i < `STQ_DEPTH; i += 2) update_entries(i, i + 1);
    drain_entry(2);  // entry 2 stops matching but waits behind the head.
    repeat (2) idle_cycle();
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (i != 2) drain_entry(i);
    end
    while (count != 0) idle_cycle();

    test_name = "youngest";
    for (int i = 0; i < 6; i += 2) write_stores(store_fp(16 + i), store_fp(17 + i), 1'b1);
    for (int i = 0; i < 6; i += 2) update_entries(i, i + 1);
    for (int i = 0; i < 6; i++) drain_entry(i);
    while (count != 0) idle_cycle();
    set_check(0, 1'b1, make_fp(36'h300, 1'b1, 4'h2, 8'h04));
    set_check(1, 1'b1, make_fp(36'h300, 1'b1, 4'h8, 8'h0c));
    write_stores(make_fp(36'h300, 1'b1, 4'ha, 8'h0c), make_fp(36'h300, 1'b1, 4'ha, 8'h0c), 1'b1);
    write_stores(make_fp(36'h300, 1'b1, 4'ha, 8'h0c), make_fp(36'h300, 1'b1, 4'ha, 8'h0c), 1'b1);
    update_entries(6, 7);
    update_entries(0, 1);  // the ring has wrapped, entry 1 is now the youngest.
    repeat (2) idle_cycle();
    drain_entry(1);
    repeat (2) idle_cycle();
    drain_entry(6);
    drain_entry(7);
    drain_entry(0);
    while (count != 0) idle_cycle();

    test_name = "random";
    for (int n = 0; n < RAND_CYCLES; n++) begin
      @(posedge clk);
      clear_strobes();
      r = $random(seed);
      draw_fp(f0);
      draw_fp(f1);
      wrt[0].en <= r[0] && r[1];
      wrt[0].fp <= f0;
      wrt[1].en <= r[0] && r[1] && r[2];
      wrt[1].fp <= f1;
      upd_en <= r[4:3];
      upd_idx[0] <= r[7:5];
      upd_idx[1] <= m_head + stq_ctrl_pkg::idx_t'(r[9:8]);
      drain_en <= r[10] || r[11];
      drain_idx <= m_head + stq_ctrl_pkg::idx_t'(r[12]);
      draw_fp(f0);
      draw_fp(f1);
      set_check(0, r[13] || r[14], f0);
      set_check(1, r[15] || r[16], f1);
    end

    test_name = "final drain";
    while (m_count != 0) begin
      @(posedge clk);
      clear_strobes();
      drain_en <= 1'b1;
      drain_idx <= m_head;
    end
    for (int p = 0; p < `STQ_CHK_PORTS; p++) chk[p].en <= 1'b0;
    repeat (3) idle_cycle();

    if (errors == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_run("errors were counted during the run.");
    end
  end

endmodule

// File: stq.f
+incdir+source
source/stq_addr_pkg.sv
source/stq_ctrl_pkg.sv
source/stq_entry.sv
source/stq_alloc.sv
source/stq_check_merge.sv
source/stq_top.sv
test/stq_tb.sv
